/* include/grn_defines.svh */
`ifndef GRN_DEFINES_SVH
`define GRN_DEFINES_SVH

// ----------------------------------------
// Network shape.
// ----------------------------------------

// One bit per gene in a network state.
`define GRN_NODES 5

`define GRN_ID_WIDTH 1  // Network ID field of an input word.

// ----------------------------------------
// Search and buffering.
// ----------------------------------------

// Width of the transient and period counters.
`define GRN_COUNT_WIDTH 29

`define GRN_FIFO_DEPTH_BITS 4  // Sixteen entries.

// Network ID answered when none is given.
`define GRN_DEFAULT_ID 0

`endif

/* src/grn_pkg.sv */
`include "grn_defines.svh"

package grn_pkg;

  // Bit 0 CtrA, bit 1 GcrA, bit 2 SciP, bit 3 DnaA, bit 4 CcrM.
  typedef logic [`GRN_NODES-1:0] grn_state_t;
  typedef logic [`GRN_COUNT_WIDTH-1:0] grn_count_t;
  typedef logic [`GRN_ID_WIDTH-1:0] grn_id_t;

  typedef struct packed {
    grn_state_t last_state;
    grn_state_t first_state;
  } grn_request_t;

  // Word as it arrives on the input port.
  typedef struct packed {
    grn_request_t request;
    grn_id_t      id;
  } grn_in_word_t;

  typedef struct packed {
    grn_state_t state;      // Meeting state.
    grn_count_t transient;
    grn_count_t period;
  } grn_result_t;

  typedef enum logic [2:0] {
    st_idle, st_fetch, st_load, st_reset_net,
    st_run_search, st_measure_period, st_emit, st_finish
  } grn_ctrl_state_e;

endpackage

/* src/grn_fifo.sv */
`include "grn_defines.svh"

module grn_fifo #(
  parameter int width      = 8,
  parameter int depth_bits = `GRN_FIFO_DEPTH_BITS
) (
  input  logic             clk,
  input  logic             rst_nos,
  input  logic             we,
  input  logic [width-1:0] din,
  input  logic             re,
  output logic [width-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int depth = 2 ** depth_bits;

  logic [width-1:0]      mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0]   count;  // One bit wider than the pointers.
  logic                  do_write;
  logic                  do_read;

  assign do_write = we && !full;
  assign do_read  = re && !empty;

  assign empty = (count == '0);
  assign full  = count[depth_bits];  // Count never exceeds the depth.

  // ----------------------------------------
  // Pointers and occupancy.
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst_nos) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither keep the count.
      endcase
    end
  end

  // ----------------------------------------
  // Storage.
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
    // Read data shows up the cycle after re.
    if (do_read) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule

/* src/grn_input_filter.sv */
`include "grn_defines.svh"

module grn_input_filter #(
  parameter grn_pkg::grn_id_t node_id = `GRN_DEFAULT_ID
) (
  input  logic                  clk,
  input  logic                  rst_nos,
  input  logic                  in_valid,
  input  grn_pkg::grn_in_word_t in_word,
  input  logic                  fifo_full,
  output logic                  fifo_we,
  output grn_pkg::grn_request_t fifo_data
);

  import grn_pkg::*;

  grn_id_t word_id;
  logic    accept;

  assign word_id = in_word.id;

  // Words for other networks, or arriving on a full FIFO, are lost.
  assign accept = in_valid && (word_id == node_id) && !fifo_full;

  always_ff @(posedge clk) begin
    if (rst_nos) begin
      fifo_we <= 1'b0;
    end else begin
      fifo_we <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      fifo_data <= in_word.request;
    end
  end

endmodule

/* src/grn_network.sv */
module grn_network (
  input  logic                clk,
  input  logic                load,
  input  grn_pkg::grn_state_t init_state,
  input  logic                slow_step,
  input  logic                fast_step,
  output grn_pkg::grn_state_t slow_state,
  output grn_pkg::grn_state_t fast_state
);

  import grn_pkg::*;

  logic slow_turn;  // Slow copy updates on this enabled cycle.

  // Synchronous update of all five genes.
  function automatic grn_state_t next_state(input grn_state_t s);
    logic       ctra;
    logic       gcra;
    logic       scip;
    logic       dnaa;
    logic       ccrm;
    grn_state_t n;
    ctra = s[0];
    gcra = s[1];
    scip = s[2];
    dnaa = s[3];
    ccrm = s[4];
    n[0] = (ctra | gcra) & ~ccrm & ~scip;
    n[1] = dnaa & ~ctra;
    n[2] = ctra & ~dnaa;
    n[3] = ctra & ccrm & ~gcra & ~dnaa;
    n[4] = ctra & ~ccrm & ~scip;
    return n;
  endfunction

  // ----------------------------------------
  // Slow trajectory at half rate.
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      slow_state <= init_state;
      slow_turn  <= 1'b1;
    end else if (slow_step) begin
      if (slow_turn) begin
        slow_state <= next_state(slow_state);
      end
      slow_turn <= !slow_turn;
    end
  end

  // Fast trajectory steps once per enable.
  always_ff @(posedge clk) begin
    if (load) begin
      fast_state <= init_state;
    end else if (fast_step) begin
      fast_state <= next_state(fast_state);
    end
  end

endmodule

/* src/grn_attractor_ctrl.sv */
module grn_attractor_ctrl (
  input  logic                  clk,
  input  logic                  rst_nos,
  input  logic                  in_empty,
  output logic                  in_re,
  input  grn_pkg::grn_request_t request,
  input  logic                  end_data_in,
  input  logic                  out_full,
  input  logic                  out_empty,
  output logic                  out_we,
  output grn_pkg::grn_result_t  result,
  output logic                  done,
  output logic                  load,
  output grn_pkg::grn_state_t   init_state,
  output logic                  slow_step,
  output logic                  fast_step,
  input  grn_pkg::grn_state_t   slow_state,
  input  grn_pkg::grn_state_t   fast_state
);

  import grn_pkg::*;

  grn_ctrl_state_e state;

  grn_state_t cur_state;      // Initial state under search.
  grn_state_t last_state;
  grn_state_t meet_state;
  grn_count_t step_cnt;       // Slow steps so far.
  grn_count_t transient_val;
  grn_count_t period_cnt;
  logic       odd_cycle;      // Fast copy is one step past 2 * step_cnt.
  logic       data_wait;
  logic [1:0] settle;

  logic meet;
  logic returned;
  logic more_states;
  logic all_quiet;

  // Compare only when the fast copy has taken exactly twice the slow steps.
  assign meet = (state == st_run_search) && !odd_cycle && (step_cnt != '0) &&
                (slow_state == fast_state);
  assign returned = (state == st_measure_period) && (period_cnt != '0) &&
                    (fast_state == meet_state);
  assign more_states = (cur_state < last_state);
  assign all_quiet = in_empty && end_data_in && out_empty;

  assign load       = (state == st_reset_net);
  assign init_state = cur_state;
  assign slow_step  = (state == st_run_search) && !meet;
  assign fast_step  = slow_step || ((state == st_measure_period) && !returned);

  // ----------------------------------------
  // FSM and strobes.
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst_nos) begin
      state     <= st_idle;
      in_re     <= 1'b0;
      out_we    <= 1'b0;
      done      <= 1'b0;
      data_wait <= 1'b0;
      settle    <= '0;
    end else begin
      in_re  <= 1'b0;
      out_we <= 1'b0;
      case (state)
        st_idle: begin
          if (!in_empty) begin
            state <= st_fetch;
          end else if (end_data_in) begin
            state <= st_finish;
          end
        end
        st_fetch: begin
          in_re     <= 1'b1;
          data_wait <= 1'b1;
          state     <= st_load;
        end
        st_load: begin
          data_wait <= 1'b0;
          if (!data_wait) begin
            state <= st_reset_net;  // Request captured this cycle.
          end
        end
        st_reset_net: state <= st_run_search;
        st_run_search: begin
          if (meet) begin
            state <= st_measure_period;
          end
        end
        st_measure_period: begin
          if (returned) begin
            state <= st_emit;
          end
        end
        st_emit: begin
          if (!out_full) begin
            out_we <= 1'b1;
            state  <= more_states ? st_reset_net : st_idle;
          end
        end
        st_finish: begin
          // A late word may still be in the filter, so wait a few cycles.
          if (!in_empty) begin
            settle <= '0;
            state  <= st_fetch;
          end else if (all_quiet) begin
            if (settle == 2'd3) begin
              done <= 1'b1;
            end else begin
              settle <= settle + 1'b1;
            end
          end else begin
            settle <= '0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // Search datapath.
  // ----------------------------------------

  always_ff @(posedge clk) begin
    case (state)
      st_load: begin
        if (!data_wait) begin
          cur_state  <= request.first_state;
          last_state <= request.last_state;
        end
      end
      st_reset_net: begin
        step_cnt   <= '0;
        period_cnt <= '0;
        odd_cycle  <= 1'b0;
      end
      st_run_search: begin
        if (meet) begin
          meet_state    <= slow_state;
          transient_val <= (slow_state == cur_state) ? '0 : step_cnt;
        end else begin
          odd_cycle <= !odd_cycle;
          if (odd_cycle) begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
      end
      st_measure_period: begin
        if (!returned) begin
          period_cnt <= period_cnt + 1'b1;
        end
      end
      st_emit: begin
        if (!out_full) begin
          result <= '{state: meet_state, transient: transient_val, period: period_cnt};
          if (more_states) begin
            cur_state <= cur_state + 1'b1;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

/* src/grn_top.sv */
`include "grn_defines.svh"

module grn_top #(
  parameter grn_pkg::grn_id_t node_id = `GRN_DEFAULT_ID
) (
  input  logic                  clk,
  input  logic                  rst_nos,
  input  logic                  in_valid,
  input  grn_pkg::grn_in_word_t in_word,
  input  logic                  end_data_in,
  input  logic                  read_en,
  output logic                  has_data,
  output grn_pkg::grn_result_t  data_out,
  output logic                  task_done
);

  import grn_pkg::*;

  logic         in_we;
  grn_request_t in_din;
  logic         in_re;
  grn_request_t in_dout;
  logic         in_empty;
  logic         in_full;

  logic         out_we;
  grn_result_t  out_din;
  logic         out_empty;
  logic         out_full;

  logic         net_load;
  grn_state_t   net_init;
  logic         slow_step;
  logic         fast_step;
  grn_state_t   slow_state;
  grn_state_t   fast_state;

  assign has_data = !out_empty;

  // ----------------------------------------
  // Request path.
  // ----------------------------------------

  grn_input_filter #(.node_id(node_id)) u_filter (
    .clk(clk),
    .rst_nos(rst_nos),
    .in_valid(in_valid),
    .in_word(in_word),
    .fifo_full(in_full),
    .fifo_we(in_we),
    .fifo_data(in_din)
  );

  grn_fifo #(
    .width($bits(grn_request_t)),
    .depth_bits(`GRN_FIFO_DEPTH_BITS)
  ) u_in_fifo (
    .clk(clk),
    .rst_nos(rst_nos),
    .we(in_we),
    .din(in_din),
    .re(in_re),
    .dout(in_dout),
    .empty(in_empty),
    .full(in_full)
  );

  grn_attractor_ctrl u_ctrl (
    .clk(clk),
    .rst_nos(rst_nos),
    .in_empty(in_empty),
    .in_re(in_re),
    .request(in_dout),
    .end_data_in(end_data_in),
    .out_full(out_full),
    .out_empty(out_empty),
    .out_we(out_we),
    .result(out_din),
    .done(task_done),
    .load(net_load),
    .init_state(net_init),
    .slow_step(slow_step),
    .fast_step(fast_step),
    .slow_state(slow_state),
    .fast_state(fast_state)
  );

  grn_network u_network (
    .clk(clk),
    .load(net_load),
    .init_state(net_init),
    .slow_step(slow_step),
    .fast_step(fast_step),
    .slow_state(slow_state),
    .fast_state(fast_state)
  );

  // Results wait here for the outside reader.
  grn_fifo #(
    .width($bits(grn_result_t)),
    .depth_bits(`GRN_FIFO_DEPTH_BITS)
  ) u_out_fifo (
    .clk(clk),
    .rst_nos(rst_nos),
    .we(out_we),
    .din(out_din),
    .re(read_en),
    .dout(data_out),
    .empty(out_empty),
    .full(out_full)
  );

endmodule

/* sim/tb_grn_top.sv */
module tb_grn_top;
  timeunit 1ns;
  timeprecision 100ps;

  import grn_pkg::*;

  localparam string tests_file = "sim/grn_tests.txt";

  logic         clk;
  logic         rst_nos;
  logic         in_valid;
  grn_in_word_t in_word;
  logic         end_data_in;
  logic         read_en;
  logic         has_data;
  grn_result_t  data_out;
  logic         task_done;

  grn_in_word_t req_q[$];
  grn_result_t  exp_q[$];
  int   hold_index = -1;  // Results read before reads are withheld.
  int   hold_cycles = 0;
  int   range_sum = 0;
  int   expected_count = 0;
  int   results_read = 0;
  int   errors_value = 0;
  int   errors_other = 0;
  int   cycle_count = 0;
  int   cycle_limit = 2000;
  int   seed = 62;
  logic early_done_seen = 1'b0;

  grn_top #(.node_id(1'b0)) UUT (
    .clk(clk),
    .rst_nos(rst_nos),
    .in_valid(in_valid),
    .in_word(in_word),
    .end_data_in(end_data_in),
    .read_en(read_en),
    .has_data(has_data),
    .data_out(data_out),
    .task_done(task_done)
  );

  always #50 clk = ~clk;

  // ----------------------------------------
  // Test file and checks.
  // ----------------------------------------

  task automatic check_record_fields(input string tag, input int got, input int wanted);
    if (got != wanted) begin
      $display("Test file record %s has %0d of %0d fields", tag, got, wanted);
      errors_other++;
    end
  endtask

  task automatic load_tests();
    int           fd;
    int           code;
    int           listed;
    string        tag;
    string        line;
    logic [31:0]  f1;
    logic [31:0]  f2;
    logic [31:0]  f3;
    grn_in_word_t word;
    grn_result_t  res;
    listed = -1;
    fd = $fopen(tests_file, "r");
    if (fd == 0) begin
      $display("Cannot open test file %s", tests_file);
      errors_other++;
      return;
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag.getc(0) == "#") begin
        code = $fgets(line, fd);  // Rest of a comment.
      end else if (tag == "req") begin
        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
        check_record_fields(tag, code, 3);
        word.id = f1[0];
        word.request.first_state = f2[4:0];
        word.request.last_state = f3[4:0];
        req_q.push_back(word);
        range_sum += (f2 <= f3) ? (f3 - f2 + 1) : 1;
      end else if (tag == "exp") begin
        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
        check_record_fields(tag, code, 3);
        res.state = f1[4:0];
        res.transient = f2[28:0];
        res.period = f3[28:0];
        exp_q.push_back(res);
      end else if (tag == "hold") begin
        code = $fscanf(fd, "%h", f1);
        check_record_fields(tag, code, 1);
        hold_index = exp_q.size();
        hold_cycles = f1;
      end else if (tag == "count") begin
        code = $fscanf(fd, "%h", f1);
        check_record_fields(tag, code, 1);
        listed = f1;
      end else begin
        $display("Unknown record %s in test file", tag);
        errors_other++;
        code = $fgets(line, fd);
      end
    end
    $fclose(fd);
    expected_count = exp_q.size();
    if (listed != expected_count) begin
      $display("Test file lists %0d results but its count says %0d", expected_count, listed);
      errors_other++;
    end
  endtask

  task automatic check_result(input int idx, input grn_result_t expected,
                              input grn_result_t actual);
    if (actual !== expected) begin
      errors_value++;
      $display("FAIL data_out result %0d: expected %h, got %h", idx, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      errors_value++;
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic print_summary();
    $display("Results read %0d of %0d, value errors %0d, other errors %0d",
             results_read, expected_count, errors_value, errors_other);
  endtask

  // Inputs change and outputs are sampled 5 ns past the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // ----------------------------------------
  // Stimulus and reader.
  // ----------------------------------------

  task automatic send_requests();
    foreach (req_q[k]) begin
      in_valid = 1'b1;
      in_word = req_q[k];
      next_cycle();
      in_valid = 1'b0;
      next_cycle();
    end
    repeat (4) next_cycle();
    end_data_in = 1'b1;  // Held high to the end.
  endtask

  task automatic read_results();
    logic held;
    held = 1'b0;
    while (results_read < expected_count) begin
      next_cycle();
      if (read_en) begin
        check_result(results_read, exp_q[results_read], data_out);
        results_read++;
      end
      read_en = 1'b0;
      if (!held && results_read == hold_index) begin
        held = 1'b1;
        repeat (hold_cycles) next_cycle();  // Output FIFO fills and the search stalls.
        check_flag("has_data", has_data, 1'b1);
      end
      if (has_data && results_read < expected_count && ($random(seed) & 3) != 0) begin
        read_en = 1'b1;
      end
    end
  endtask

  // Watchdog and early done check.
  always @(negedge clk) begin
    if (!rst_nos) begin
      cycle_count++;
      if (task_done && !early_done_seen &&
          (!end_data_in || results_read < expected_count)) begin
        early_done_seen = 1'b1;
        errors_other++;
        $display("task_done rose before all %0d results were read", expected_count);
      end
      if (cycle_count >= cycle_limit) begin
        $display("Timeout after %0d cycles with %0d of %0d results read",
                 cycle_count, results_read, expected_count);
        errors_other++;
        print_summary();
        $display("SIMULATION FAILED");
        $finish;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst_nos = 1'b1;
    in_valid = 1'b0;
    in_word = '0;
    end_data_in = 1'b0;
    read_en = 1'b0;
    load_tests();
    cycle_limit = range_sum * 200 + 2000;
    repeat (4) @(posedge clk);
    #5;
    rst_nos = 1'b0;
    next_cycle();
    check_flag("has_data", has_data, 1'b0);
    check_flag("task_done", task_done, 1'b0);
    fork
      send_requests();
      read_results();
    join
    while (!task_done) begin
      next_cycle();
    end
    // Done is sticky and nothing extra is left behind.
    repeat (8) begin
      next_cycle();
      check_flag("task_done", task_done, 1'b1);
      check_flag("has_data", has_data, 1'b0);
    end
    print_summary();
    if (errors_value == 0 && errors_other == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sim/grn_tests.txt */
# req <id> <first> <last> | exp <state> <transient> <period> | hold <cycles> | count <results>
# All values hex. exp records follow the order in which results leave the DUT.
req 0 00 00
exp 00 0 1
# Another network's ID, no results.
req 1 00 1f
# First above last, only the first state.
req 0 09 03
exp 01 4 4
hold 400
req 0 00 1f
exp 00 0 1
exp 01 0 4
exp 02 0 4
exp 01 4 4
exp 00 1 1
exp 00 2 1
exp 00 1 1
exp 00 2 1
exp 0c 4 4  # 08
exp 01 4 4
exp 02 4 4
exp 01 4 4
exp 0c 0 4  # 0c
exp 00 1 1
exp 0c 4 4
exp 00 1 1
exp 00 1 1  # 10
exp 15 4 4
exp 00 1 1
exp 00 2 1
exp 00 1 1
exp 15 0 4
exp 00 1 1
exp 00 2 1
exp 0c 4 4  # 18
exp 00 1 1
exp 0c 4 4
exp 00 1 1
exp 0c 4 4
exp 00 1 1
exp 0c 4 4
exp 00 1 1
req 1 05 05
req 0 11 11
exp 15 4 4
count 23

/* sim.f */
+incdir+include
src/grn_pkg.sv
src/grn_fifo.sv
src/grn_input_filter.sv
src/grn_network.sv
src/grn_attractor_ctrl.sv
src/grn_top.sv
sim/tb_grn_top.sv

/* Bender.yml */
package:
  name: grn_attractor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/grn_pkg.sv
      - src/grn_fifo.sv
      - src/grn_input_filter.sv
      - src/grn_network.sv
      - src/grn_attractor_ctrl.sv
      - src/grn_top.sv
  - target: simulation
    files:
      - sim/tb_grn_top.sv
